/* sram_axi_cfg.svh */
`ifndef SRAM_AXI_CFG_SVH
`define SRAM_AXI_CFG_SVH

// AXI bus widths
`define AXI_ID_BITS    4
`define AXI_ADDR_BITS  32
`define AXI_DATA_BITS  32
`define AXI_STRB_BITS  4

// Burst length field, up to 16 beats
`define AXI_LEN_BITS   4

// Word address into the SRAM, 16K words of 32 bits
`define SRAM_ADDR_BITS 14

`endif

/* sram_axi_pkg.sv */
`include "sram_axi_cfg.svh"

package sram_axi_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // Shared by AW and AR
    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_ADDR_BITS-1:0] addr;
        logic [`AXI_LEN_BITS-1:0]  len;
        logic [2:0]                size;
        axi_burst_e                burst;
    } axi_ax_t;

    typedef struct packed {
        logic [`AXI_DATA_BITS-1:0] data;
        logic [`AXI_STRB_BITS-1:0] strb;
        logic                      last;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_BITS-1:0] id;
        axi_resp_e               resp;
    } axi_b_t;

    typedef struct packed {
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_DATA_BITS-1:0] data;
        axi_resp_e                 resp;
        logic                      last;
    } axi_r_t;

    // One word access on the SRAM port
    typedef struct packed {
        logic [`SRAM_ADDR_BITS-1:0] addr;
        logic [`AXI_DATA_BITS-1:0]  wdata;
        logic [`AXI_STRB_BITS-1:0]  be;
        logic                       we;
    } sram_req_t;

endpackage

/* axi_chan_slice.sv */
`timescale 1ns/1ps

module axi_chan_slice #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    logic in_fire;

    // Takes a new item while the held one leaves
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data <= in_data;
        end
    end

endmodule

/* sram_write_ctrl.sv */
`timescale 1ns/1ps
`include "sram_axi_cfg.svh"

module sram_write_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  sram_axi_pkg::axi_ax_t   aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  sram_axi_pkg::axi_w_t    w,
    input  logic                    w_valid,
    output logic                    w_ready,
    output sram_axi_pkg::axi_b_t    b,
    output logic                    b_valid,
    input  logic                    b_ready,
    output sram_axi_pkg::sram_req_t req,
    output logic                    req_valid,
    input  logic                    grant
);
    import sram_axi_pkg::*;

    localparam int WORD_BITS = `AXI_ADDR_BITS - 2;

    logic                    busy;
    logic                    err_q;
    logic [`AXI_ID_BITS-1:0] id_q;
    logic [WORD_BITS-1:0]    addr_q;
    axi_burst_e              burst_q;
    logic                    out_of_range;
    logic                    aw_fire;
    logic                    beat_fire;

    // Any word address bit above the SRAM depth
    assign out_of_range = |addr_q[WORD_BITS-1:`SRAM_ADDR_BITS];

    // New burst only after the previous B has gone
    assign aw_ready  = !busy && !b_valid;
    assign aw_fire   = aw_valid && aw_ready;
    assign req_valid = busy && w_valid;
    assign w_ready   = grant;
    assign beat_fire = req_valid && grant;

    always_comb begin
        req.addr  = addr_q[`SRAM_ADDR_BITS-1:0];
        req.wdata = w.data;
        req.be    = out_of_range ? '0 : w.strb;
        req.we    = 1'b1;
        b.id      = id_q;
        b.resp    = err_q ? RESP_SLVERR : RESP_OKAY;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy    <= 1'b0;
            err_q   <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            if (aw_fire) begin
                busy  <= 1'b1;
                err_q <= 1'b0;
            end else if (beat_fire) begin
                err_q <= err_q | out_of_range;
                if (w.last) begin
                    busy    <= 1'b0;
                    b_valid <= 1'b1;
                end
            end
        end
    end

    // WRAP steps like INCR
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q    <= aw.id;
            addr_q  <= aw.addr[`AXI_ADDR_BITS-1:2];
            burst_q <= aw.burst;
        end else if (beat_fire && burst_q != BURST_FIXED) begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

/* sram_read_ctrl.sv */
`timescale 1ns/1ps
`include "sram_axi_cfg.svh"

module sram_read_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  sram_axi_pkg::axi_ax_t     ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    output sram_axi_pkg::axi_r_t      r,
    output logic                      r_valid,
    input  logic                      r_ready,
    output sram_axi_pkg::sram_req_t   req,
    output logic                      req_valid,
    input  logic                      grant,
    input  logic [`AXI_DATA_BITS-1:0] rdata
);
    import sram_axi_pkg::*;

    localparam int WORD_BITS = `AXI_ADDR_BITS - 2;

    logic                     busy;
    logic                     pend;
    logic                     pend_last;
    logic                     pend_err;
    logic [`AXI_ID_BITS-1:0]  id_q;
    logic [WORD_BITS-1:0]     addr_q;
    logic [`AXI_LEN_BITS-1:0] len_q;
    logic [`AXI_LEN_BITS-1:0] cnt_q;
    axi_burst_e               burst_q;
    logic                     out_of_range;
    logic                     ar_fire;

    assign out_of_range = |addr_q[WORD_BITS-1:`SRAM_ADDR_BITS];
    assign ar_ready     = !busy;
    assign ar_fire      = ar_valid && ar_ready;

    // One beat in flight, and only if the R register frees up in time
    assign req_valid = busy && !pend && (!r_valid || r_ready);

    always_comb begin
        req.addr  = addr_q[`SRAM_ADDR_BITS-1:0];
        req.wdata = '0;
        req.be    = '0;
        req.we    = 1'b0;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy    <= 1'b0;
            pend    <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            pend <= grant;
            if (ar_fire) begin
                busy <= 1'b1;
            end else if (grant && cnt_q == len_q) begin
                busy <= 1'b0;
            end
            if (pend) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q    <= ar.id;
            addr_q  <= ar.addr[`AXI_ADDR_BITS-1:2];
            len_q   <= ar.len;
            burst_q <= ar.burst;
            cnt_q   <= '0;
        end else if (grant) begin
            cnt_q <= cnt_q + 1'b1;
            if (burst_q != BURST_FIXED) begin
                addr_q <= addr_q + 1'b1;
            end
        end
        if (grant) begin
            pend_last <= (cnt_q == len_q);
            pend_err  <= out_of_range;
        end
        // SRAM data is valid the cycle after the grant
        if (pend) begin
            r.id   <= id_q;
            r.data <= pend_err ? '0 : rdata;
            r.resp <= pend_err ? RESP_SLVERR : RESP_OKAY;
            r.last <= pend_last;
        end
    end

endmodule

/* sram_port_arb.sv */
`timescale 1ns/1ps

module sram_port_arb (
    input  logic                    clk,
    input  logic                    rst,
    input  sram_axi_pkg::sram_req_t wr_req,
    input  logic                    wr_valid,
    output logic                    wr_grant,
    input  sram_axi_pkg::sram_req_t rd_req,
    input  logic                    rd_valid,
    output logic                    rd_grant,
    output sram_axi_pkg::sram_req_t mem_req,
    output logic                    mem_en
);

    // Set when the read path won the last granted cycle
    logic last_rd;

    always_comb begin
        wr_grant = 1'b0;
        rd_grant = 1'b0;
        if (wr_valid && rd_valid) begin
            rd_grant = !last_rd;
            wr_grant = last_rd;
        end else begin
            wr_grant = wr_valid;
            rd_grant = rd_valid;
        end
    end

    assign mem_en  = wr_grant || rd_grant;
    assign mem_req = rd_grant ? rd_req : wr_req;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            last_rd <= 1'b0;
        end else if (mem_en) begin
            last_rd <= rd_grant;
        end
    end

endmodule

/* sram_array.sv */
`timescale 1ns/1ps
`include "sram_axi_cfg.svh"

module sram_array (
    input  logic                      clk,
    input  sram_axi_pkg::sram_req_t   mem_req,
    input  logic                      mem_en,
    output logic [`AXI_DATA_BITS-1:0] rdata
);

    localparam int DEPTH = 2 ** `SRAM_ADDR_BITS;

    logic [`AXI_DATA_BITS-1:0] mem [DEPTH];

    // Byte lanes write on their own enable
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_req.we) begin
                for (int i = 0; i < `AXI_STRB_BITS; i++) begin
                    if (mem_req.be[i]) begin
                        mem[mem_req.addr][8*i +: 8] <= mem_req.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[mem_req.addr];
            end
        end
    end

endmodule

/* sram_axi_top.sv */
`timescale 1ns/1ps
`include "sram_axi_cfg.svh"

module sram_axi_top (
    input  logic                  clk,
    input  logic                  rst,
    input  sram_axi_pkg::axi_ax_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  sram_axi_pkg::axi_w_t  w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output sram_axi_pkg::axi_b_t  b,
    output logic                  b_valid,
    input  logic                  b_ready,
    input  sram_axi_pkg::axi_ax_t ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output sram_axi_pkg::axi_r_t  r,
    output logic                  r_valid,
    input  logic                  r_ready
);
    import sram_axi_pkg::*;

    axi_ax_t                   aw_s;
    axi_ax_t                   ar_s;
    axi_w_t                    w_s;
    logic                      aw_s_valid;
    logic                      aw_s_ready;
    logic                      ar_s_valid;
    logic                      ar_s_ready;
    logic                      w_s_valid;
    logic                      w_s_ready;
    sram_req_t                 wr_req;
    sram_req_t                 rd_req;
    sram_req_t                 mem_req;
    logic                      wr_valid;
    logic                      wr_grant;
    logic                      rd_valid;
    logic                      rd_grant;
    logic                      mem_en;
    logic [`AXI_DATA_BITS-1:0] rdata;

    axi_chan_slice #(.payload_t(axi_ax_t)) i_aw_slice (
        .clk(clk), .rst(rst),
        .in_data(aw), .in_valid(aw_valid), .in_ready(aw_ready),
        .out_data(aw_s), .out_valid(aw_s_valid), .out_ready(aw_s_ready)
    );

    axi_chan_slice #(.payload_t(axi_w_t)) i_w_slice (
        .clk(clk), .rst(rst),
        .in_data(w), .in_valid(w_valid), .in_ready(w_ready),
        .out_data(w_s), .out_valid(w_s_valid), .out_ready(w_s_ready)
    );

    axi_chan_slice #(.payload_t(axi_ax_t)) i_ar_slice (
        .clk(clk), .rst(rst),
        .in_data(ar), .in_valid(ar_valid), .in_ready(ar_ready),
        .out_data(ar_s), .out_valid(ar_s_valid), .out_ready(ar_s_ready)
    );

    sram_write_ctrl i_write_ctrl (
        .clk(clk), .rst(rst),
        .aw(aw_s), .aw_valid(aw_s_valid), .aw_ready(aw_s_ready),
        .w(w_s), .w_valid(w_s_valid), .w_ready(w_s_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .req(wr_req), .req_valid(wr_valid), .grant(wr_grant)
    );

    sram_read_ctrl i_read_ctrl (
        .clk(clk), .rst(rst),
        .ar(ar_s), .ar_valid(ar_s_valid), .ar_ready(ar_s_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .req(rd_req), .req_valid(rd_valid), .grant(rd_grant),
        .rdata(rdata)
    );

    sram_port_arb i_port_arb (
        .clk(clk), .rst(rst),
        .wr_req(wr_req), .wr_valid(wr_valid), .wr_grant(wr_grant),
        .rd_req(rd_req), .rd_valid(rd_valid), .rd_grant(rd_grant),
        .mem_req(mem_req), .mem_en(mem_en)
    );

    sram_array i_sram (
        .clk(clk),
        .mem_req(mem_req),
        .mem_en(mem_en),
        .rdata(rdata)
    );

endmodule

/* sram_axi_sva.sv */
`timescale 1ns/1ps

module sram_axi_sva (
    input logic                 clk,
    input logic                 rst,
    input sram_axi_pkg::axi_b_t b,
    input logic                 b_valid,
    input logic                 b_ready,
    input sram_axi_pkg::axi_r_t r,
    input logic                 r_valid,
    input logic                 r_ready,
    input logic                 wr_valid,
    input logic                 wr_grant,
    input logic                 rd_valid,
    input logic                 rd_grant
);

    b_hold: assert property (@(posedge clk) disable iff (!rst)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("B valid dropped or payload changed before b_ready");

    r_hold: assert property (@(posedge clk) disable iff (!rst)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("R valid dropped or payload changed before r_ready");

    // Response valids stay low while in reset
    idle_in_reset: assert property (@(posedge clk) !rst |-> !b_valid && !r_valid)
        else $error("Response valid high during reset");

    // Loser of a conflict wins the next cycle
    wr_turn: assert property (@(posedge clk) disable iff (!rst)
        wr_valid && rd_grant |=> wr_grant || !wr_valid)
        else $error("Write request passed over twice in a row");

    rd_turn: assert property (@(posedge clk) disable iff (!rst)
        rd_valid && wr_grant |=> rd_grant || !rd_valid)
        else $error("Read request passed over twice in a row");

endmodule

bind sram_axi_top sram_axi_sva i_sva (
    .clk(clk), .rst(rst),
    .b(b), .b_valid(b_valid), .b_ready(b_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready),
    .wr_valid(wr_valid), .wr_grant(wr_grant),
    .rd_valid(rd_valid), .rd_grant(rd_grant)
);

/* sram_axi_tb.sv */
`timescale 1ns/1ps
`include "sram_axi_cfg.svh"

module sram_axi_tb;
    import sram_axi_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_ROWS    = 18;
    localparam int BOTH_OFFSET = 32'h800;
    localparam int MEM_WORDS   = 1 << `SRAM_ADDR_BITS;
    localparam int TIMEOUT     = NUM_ROWS * 17 * 20 * CLK_PERIOD + 8 * CLK_PERIOD;
    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_BOTH = 2'd2;

    typedef struct packed {
        logic [1:0]                op;
        logic [`AXI_ID_BITS-1:0]   id;
        logic [`AXI_ADDR_BITS-1:0] addr;
        logic [`AXI_LEN_BITS-1:0]  len;
        axi_burst_e                burst;
        logic [`AXI_STRB_BITS-1:0] strb;
        logic [`AXI_DATA_BITS-1:0] seed;
        logic [15:0]               stall;
    } test_row_t;

    logic clk;
    logic rst;
    axi_ax_t aw;
    logic aw_valid;
    logic aw_ready;
    axi_w_t w;
    logic w_valid;
    logic w_ready;
    axi_b_t b;
    logic b_valid;
    logic b_ready;
    axi_ax_t ar;
    logic ar_valid;
    logic ar_ready;
    axi_r_t r;
    logic r_valid;
    logic r_ready;

    test_row_t rows [NUM_ROWS];
    logic [7:0] ref_mem [MEM_WORDS*4];
    logic [`AXI_DATA_BITS-1:0] wbeat [16];
    logic [`AXI_DATA_BITS-1:0] exp_data [16];
    axi_resp_e exp_resp [16];
    int errors = 0;
    int checks = 0;

    sram_axi_top i_dut (
        .clk(clk), .rst(rst),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic load_table();
        // op, id, addr, len, burst, strb, data seed (0 = random), R/B stall bits
        rows[0]  = '{OP_WR,   4'h1, 32'h0000_0100, 4'd0, BURST_INCR,  4'hf, 32'h0, 16'h0000};
        rows[1]  = '{OP_RD,   4'h2, 32'h0000_0100, 4'd0, BURST_INCR,  4'hf, 32'h0, 16'h0000};
        rows[2]  = '{OP_WR,   4'h3, 32'h0000_0200, 4'd7, BURST_INCR,  4'hf, 32'h0, 16'h0000};
        rows[3]  = '{OP_RD,   4'h4, 32'h0000_0200, 4'd7, BURST_INCR,  4'hf, 32'h0, 16'h0000};
        rows[4]  = '{OP_WR,   4'h5, 32'h0000_0300, 4'd0, BURST_INCR,  4'hf, 32'ha5a5_5a5a, 16'h0};
        rows[5]  = '{OP_WR,   4'h6, 32'h0000_0300, 4'd0, BURST_INCR,  4'h4, 32'h0, 16'h0000};
        rows[6]  = '{OP_WR,   4'h7, 32'h0000_0300, 4'd0, BURST_INCR,  4'h3, 32'h0, 16'h0000};
        rows[7]  = '{OP_RD,   4'h8, 32'h0000_0300, 4'd0, BURST_INCR,  4'hf, 32'h0, 16'h0000};
        rows[8]  = '{OP_WR,   4'h9, 32'h0000_0400, 4'd0, BURST_INCR,  4'hf, 32'hcafe_f00d, 16'h0};
        rows[9]  = '{OP_WR,   4'ha, 32'h0000_0400, 4'd3, BURST_FIXED, 4'hd, 32'h0, 16'h0000};
        rows[10] = '{OP_RD,   4'hb, 32'h0000_0400, 4'd0, BURST_INCR,  4'hf, 32'h0, 16'h0000};
        rows[11] = '{OP_WR,   4'hc, 32'h0000_0500, 4'd0, BURST_INCR,  4'hf, 32'h1357_9bdf, 16'h0};
        rows[12] = '{OP_WR,   4'hd, 32'h0001_0500, 4'd0, BURST_INCR,  4'hf, 32'h0, 16'h0000};
        rows[13] = '{OP_RD,   4'he, 32'h0001_0500, 4'd1, BURST_INCR,  4'hf, 32'h0, 16'h0000};
        rows[14] = '{OP_RD,   4'hf, 32'h0000_0500, 4'd0, BURST_INCR,  4'hf, 32'h0, 16'h0000};
        rows[15] = '{OP_BOTH, 4'h1, 32'h0000_0200, 4'd7, BURST_INCR,  4'hf, 32'h0, 16'h5a3c};
        rows[16] = '{OP_BOTH, 4'h2, 32'h0000_0a00, 4'd7, BURST_INCR,  4'hf, 32'h0, 16'hc6a1};
        rows[17] = '{OP_RD,   4'h3, 32'h0000_1200, 4'd7, BURST_INCR,  4'hf, 32'h0, 16'h0f0f};
    endtask

    // Word index of a beat; WRAP steps like INCR
    function automatic int word_of(input axi_ax_t ax, input int beat);
        word_of = int'(ax.addr >> 2);
        if (ax.burst != BURST_FIXED) begin
            word_of = word_of + beat;
        end
    endfunction

    task automatic update_ref(input axi_ax_t ax, input logic [3:0] strb, input int beats,
                              output axi_resp_e resp);
        int word;
        resp = RESP_OKAY;
        for (int i = 0; i < beats; i++) begin
            word = word_of(ax, i);
            if (word >= MEM_WORDS || word < 0) begin
                resp = RESP_SLVERR;
            end else begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (strb[lane]) ref_mem[word*4+lane] = wbeat[i][8*lane +: 8];
                end
            end
        end
    endtask

    task automatic expect_read(input axi_ax_t ax, input int beats);
        int word;
        for (int i = 0; i < beats; i++) begin
            word = word_of(ax, i);
            if (word >= MEM_WORDS || word < 0) begin
                exp_data[i] = '0;
                exp_resp[i] = RESP_SLVERR;
            end else begin
                exp_data[i] = {ref_mem[word*4+3], ref_mem[word*4+2],
                               ref_mem[word*4+1], ref_mem[word*4]};
                exp_resp[i] = RESP_OKAY;
            end
        end
    endtask

    task automatic drive_aw(input axi_ax_t ax);
        @(negedge clk);
        aw = ax;
        aw_valid = 1'b1;
        @(posedge clk);
        while (!aw_ready) @(posedge clk);
        @(negedge clk);
        aw_valid = 1'b0;
    endtask

    task automatic drive_ar(input axi_ax_t ax);
        @(negedge clk);
        ar = ax;
        ar_valid = 1'b1;
        @(posedge clk);
        while (!ar_ready) @(posedge clk);
        @(negedge clk);
        ar_valid = 1'b0;
    endtask

    task automatic drive_w(input int beats, input logic [3:0] strb);
        for (int i = 0; i < beats; i++) begin
            @(negedge clk);
            w.data = wbeat[i];
            w.strb = strb;
            w.last = (i == beats - 1);
            w_valid = 1'b1;
            @(posedge clk);
            while (!w_ready) @(posedge clk);
        end
        @(negedge clk);
        w_valid = 1'b0;
    endtask

    task automatic collect_b(input logic [3:0] id, input axi_resp_e resp, input logic [15:0] stall);
        int   cyc;
        logic done;
        cyc = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            b_ready = !stall[cyc % 16];
            cyc++;
            @(posedge clk);
            if (b_valid && b_ready) begin
                check_val("b.id", b.id, id);
                check_val("b.resp", b.resp, resp);
                done = 1'b1;
            end
        end
        @(negedge clk);
        b_ready = 1'b0;
        @(posedge clk);
        check_val("b_valid", b_valid, 0);
    endtask

    task automatic collect_r(input logic [3:0] id, input int beats, input logic [15:0] stall);
        int cyc;
        int n;
        cyc = 0;
        n = 0;
        while (n < beats) begin
            @(negedge clk);
            r_ready = !stall[cyc % 16];
            cyc++;
            @(posedge clk);
            if (r_valid && r_ready) begin
                check_val("r.id", r.id, id);
                check_val("r.data", r.data, exp_data[n]);
                check_val("r.resp", r.resp, exp_resp[n]);
                check_val("r.last", r.last, n == beats - 1);
                n++;
            end
        end
        @(negedge clk);
        r_ready = 1'b0;
        // Extra beat would show up here
        @(posedge clk);
        check_val("r_valid", r_valid, 0);
    endtask

    task automatic run_row(input int idx);
        test_row_t row;
        axi_ax_t   wr_ax;
        axi_ax_t   rd_ax;
        axi_resp_e bresp;
        int        beats;
        int        err_start;
        row = rows[idx];
        beats = row.len + 1;
        err_start = errors;
        for (int i = 0; i < beats; i++) begin
            wbeat[i] = (row.seed != 0) ? row.seed + i : $urandom;
        end
        wr_ax.id = row.id;
        wr_ax.addr = row.addr;
        wr_ax.len = row.len;
        wr_ax.size = 3'd2;
        wr_ax.burst = row.burst;
        rd_ax = wr_ax;
        case (row.op)
            OP_WR: begin
                update_ref(wr_ax, row.strb, beats, bresp);
                fork
                    drive_aw(wr_ax);
                    drive_w(beats, row.strb);
                    collect_b(row.id, bresp, row.stall);
                join
            end
            OP_RD: begin
                expect_read(rd_ax, beats);
                fork
                    drive_ar(rd_ax);
                    collect_r(row.id, beats, row.stall);
                join
            end
            default: begin
                // Write lands in a region apart from the read
                wr_ax.addr = row.addr + BOTH_OFFSET;
                expect_read(rd_ax, beats);
                update_ref(wr_ax, row.strb, beats, bresp);
                fork
                    drive_aw(wr_ax);
                    drive_w(beats, row.strb);
                    collect_b(row.id, bresp, row.stall);
                    drive_ar(rd_ax);
                    collect_r(row.id, beats, row.stall);
                join
            end
        endcase
        $display("test %0d op %0d addr %h len %0d: %s", idx, row.op, row.addr, beats,
                 (errors == err_start) ? "ok" : "mismatch");
    endtask

    initial begin
        #(TIMEOUT);
        $display("Run timed out before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst = 1'b0;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        ar = '0;
        ar_valid = 1'b0;
        r_ready = 1'b0;
        void'($urandom(34));
        load_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sram_axi_top.f */
+incdir+.
sram_axi_pkg.sv
axi_chan_slice.sv
sram_write_ctrl.sv
sram_read_ctrl.sv
sram_port_arb.sv
sram_array.sv
sram_axi_top.sv
sram_axi_sva.sv
sram_axi_tb.sv

/* Bender.yml */
package:
  name: sram_axi

sources:
  - include_dirs:
      - .
    files:
      - sram_axi_pkg.sv
      - axi_chan_slice.sv
      - sram_write_ctrl.sv
      - sram_read_ctrl.sv
      - sram_port_arb.sv
      - sram_array.sv
      - sram_axi_top.sv
      - target: test
        files:
          - sram_axi_sva.sv
          - sram_axi_tb.sv
